//--- patch_subsys.f
common/patch_pkg.sv
query_patch_mem/sram_1rw1r.sv
query_patch_mem/query_patch_mem.sv
hw/patch_loader.sv
hw/patch_sad.sv
hw/patch_subsys_top.sv
sim/tb_patch_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the patch subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_patch_subsys \
    -f patch_subsys.f \
    -o sim_patch_subsys
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_patch_subsys
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation completed"
exit 0

//--- sim/tb_patch_subsys.sv
`timescale 1ns/100ps

module tb_patch_subsys;
    import patch_pkg::*;

    typedef enum logic [2:0] {PIXELS, WB_WRITE, WB_READ, QUERY, HOLD_MODE} op_e;

    logic                      clk;
    logic                      arst_n_i;
    logic                      wb_mode_i;
    logic                      pix_req_i;
    logic [PIX_W-1:0]          pix_i;
    logic                      pix_ack_o;
    logic [ADDR_W_DEF:0]       patch_count_o;
    logic                      query_req_i;
    logic [ADDR_W_DEF-1:0]     query_addr_i;
    logic [PIX_W*PATCH_SIZE-1:0] cand_patch_i;
    logic                      query_ack_o;
    logic [SAD_W-1:0]          sad_o;
    logic                      wbs_stb_i;
    logic                      wbs_cyc_i;
    logic                      wbs_we_i;
    logic [3:0]                wbs_sel_i;
    logic [31:0]               wbs_dat_i;
    logic [31:0]               wbs_adr_i;
    logic                      wbs_ack_o;
    logic [31:0]               wbs_dat_o;

    // Stimulus table, one column per field
    op_e         op_tab [$];
    int          arg_tab [$];
    logic [63:0] dat_tab [$];
    logic [63:0] exp_tab [$];

    logic [63:0] shadow [DEPTH_DEF];   // Expected row contents
    int          load_row;
    int          patch_total;
    logic [31:0] lcg_state;
    int          cycles;
    int          cycle_limit;

    patch_subsys_top #(
        .DATA_WIDTH        (PIX_W),
        .PATCH_SIZE        (PATCH_SIZE),
        .ADDR_WIDTH        (ADDR_W_DEF),
        .DEPTH             (DEPTH_DEF),
        .WB_ADDRESS_OFFSET (WB_BASE_DEF)
    ) i_dut (
        .clk (clk), .arst_n_i (arst_n_i), .wb_mode_i (wb_mode_i),
        .pix_req_i (pix_req_i), .pix_i (pix_i), .pix_ack_o (pix_ack_o),
        .patch_count_o (patch_count_o),
        .query_req_i (query_req_i), .query_addr_i (query_addr_i),
        .cand_patch_i (cand_patch_i), .query_ack_o (query_ack_o), .sad_o (sad_o),
        .wbs_stb_i (wbs_stb_i), .wbs_cyc_i (wbs_cyc_i), .wbs_we_i (wbs_we_i),
        .wbs_sel_i (wbs_sel_i), .wbs_dat_i (wbs_dat_i), .wbs_adr_i (wbs_adr_i),
        .wbs_ack_o (wbs_ack_o), .wbs_dat_o (wbs_dat_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] random_patch();
        logic [63:0] p;
        logic [31:0] r;
        p = '0;
        for (int k = 0; k < PATCH_SIZE; k++) begin
            r = lcg_next();
            p[k*PIX_W +: PIX_W] = r[26:16];   // Upper LCG bits, pixel k at bit 11k
        end
        return p;
    endfunction

    // Sum of absolute pixel differences over the patch
    function automatic int sad_model(input logic [63:0] row, input logic [63:0] cand);
        int total;
        int a;
        int b;
        total = 0;
        for (int k = 0; k < PATCH_SIZE; k++) begin
            a = int'(row[k*PIX_W +: PIX_W]);
            b = int'(cand[k*PIX_W +: PIX_W]);
            if (a >= b) total += a - b;
            else        total += b - a;
        end
        return total;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0h, expected %0h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic push_entry(input op_e op, input int arg, input logic [63:0] dat,
                              input logic [63:0] exp);
        op_tab.push_back(op);
        arg_tab.push_back(arg);
        dat_tab.push_back(dat);
        exp_tab.push_back(exp);
    endtask

    // Loader writes the zero-extended patch to its next row
    task automatic patch_entry(input logic [63:0] patch, input bit stall);
        patch_total++;
        if (stall) push_entry(HOLD_MODE, load_row, patch, 64'(patch_total));
        else       push_entry(PIXELS, load_row, patch, 64'(patch_total));
        shadow[load_row] = {9'b0, patch[54:0]};
        load_row++;
    endtask

    task automatic byte_write_entry(input int row, input int lane, input logic [7:0] val);
        push_entry(WB_WRITE, row, 64'((lane << 11) | int'(val)), 64'd0);
        shadow[row][lane*8 +: 8] = val;
    endtask

    task automatic half_read_entry(input int row, input bit hi);
        logic [63:0] exp;
        exp = hi ? {41'b0, shadow[row][54:32]} : {32'b0, shadow[row][31:0]};
        push_entry(WB_READ, row, 64'(hi) << 11, exp);
    endtask

    task automatic query_entry(input int row, input logic [63:0] cand);
        push_entry(QUERY, row, cand, 64'(sad_model(shadow[row], cand)));
    endtask

    task automatic build_table();
        logic [31:0] r;
        for (int n = 0; n < 4; n++) patch_entry(random_patch(), 1'b0);
        for (int row = 0; row < 4; row++) begin
            half_read_entry(row, 1'b0);
            half_read_entry(row, 1'b1);
        end
        r = lcg_next();
        byte_write_entry(1, 1, r[23:16]);
        r = lcg_next();
        byte_write_entry(2, 6, r[23:16]);   // Lane 6 reaches past the patch bits
        for (int row = 1; row < 3; row++) begin
            half_read_entry(row, 1'b0);
            half_read_entry(row, 1'b1);
        end
        patch_entry(random_patch(), 1'b1);   // Row 4, written only after the host lets go
        half_read_entry(4, 1'b0);
        half_read_entry(4, 1'b1);
        patch_entry(64'd0, 1'b0);            // Row 5 all zero
        for (int row = 0; row < 5; row++) query_entry(row, random_patch());
        query_entry(2, {9'b0, shadow[2][54:0]});
        query_entry(5, {9'b0, {55{1'b1}}});
    endtask

    task automatic send_pixel(input logic [PIX_W-1:0] pix);
        @(negedge clk);
        pix_req_i = 1'b1;
        pix_i     = pix;
        while (!pix_ack_o) @(negedge clk);
        pix_req_i = 1'b0;
        while (pix_ack_o) @(negedge clk);
    endtask

    task automatic stream_patch(input logic [63:0] patch, input logic [63:0] exp_count);
        for (int k = 0; k < PATCH_SIZE; k++) send_pixel(patch[k*PIX_W +: PIX_W]);
        check_value("patch_count_o after patch", 64'(patch_count_o), exp_count);
    endtask

    // Fifth pixel must wait until the host releases port 0
    task automatic stall_patch(input logic [63:0] patch, input logic [63:0] exp_count);
        @(negedge clk);
        wb_mode_i = 1'b1;
        for (int k = 0; k < PATCH_SIZE - 1; k++) send_pixel(patch[k*PIX_W +: PIX_W]);
        @(negedge clk);
        pix_req_i = 1'b1;
        pix_i     = patch[(PATCH_SIZE-1)*PIX_W +: PIX_W];
        repeat (12) @(negedge clk);
        check_value("pix_ack_o while host owns port 0", 64'(pix_ack_o), 64'd0);
        check_value("patch_count_o while stalled", 64'(patch_count_o), exp_count - 1);
        wb_mode_i = 1'b0;
        while (!pix_ack_o) @(negedge clk);
        check_value("patch_count_o after release", 64'(patch_count_o), exp_count);
        pix_req_i = 1'b0;
        while (pix_ack_o) @(negedge clk);
    endtask

    task automatic bus_cycle(input bit we, input int row, input logic [31:0] dat,
                             output logic [31:0] rdata);
        @(negedge clk);
        wb_mode_i = 1'b1;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_adr_i = 32'(row) + 32'(WB_BASE_DEF);
        wbs_dat_i = dat;
        while (!wbs_ack_o) @(negedge clk);
        rdata     = wbs_dat_o;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wb_mode_i = 1'b0;
    endtask

    task automatic run_query(input int row, input logic [63:0] cand, input logic [63:0] exp);
        int waits;
        waits = 0;
        @(negedge clk);
        query_req_i  = 1'b1;
        query_addr_i = ADDR_W_DEF'(row);
        cand_patch_i = cand[54:0];
        while (!query_ack_o) begin
            @(negedge clk);
            waits++;
        end
        check_value("query latency in cycles", 64'(waits), 64'd5);   // Ack four edges after sampling
        check_value("sad_o", 64'(sad_o), exp);
        query_req_i = 1'b0;
        while (query_ack_o) @(negedge clk);
    endtask

    task automatic apply_entry(input int i);
        logic [31:0] rdata;
        case (op_tab[i])
            PIXELS:    stream_patch(dat_tab[i], exp_tab[i]);
            HOLD_MODE: stall_patch(dat_tab[i], exp_tab[i]);
            WB_WRITE:  bus_cycle(1'b1, arg_tab[i], dat_tab[i][31:0], rdata);
            WB_READ: begin
                bus_cycle(1'b0, arg_tab[i], dat_tab[i][31:0], rdata);
                check_value($sformatf("wbs_dat_o row %0d", arg_tab[i]), 64'(rdata), exp_tab[i]);
            end
            QUERY:     run_query(arg_tab[i], dat_tab[i], exp_tab[i]);
        endcase
    endtask

    initial begin
        arst_n_i     = 1'b0;
        wb_mode_i    = 1'b0;
        pix_req_i    = 1'b0;
        pix_i        = '0;
        query_req_i  = 1'b0;
        query_addr_i = '0;
        cand_patch_i = '0;
        wbs_stb_i    = 1'b0;
        wbs_cyc_i    = 1'b0;
        wbs_we_i     = 1'b0;
        wbs_sel_i    = 4'hf;
        wbs_dat_i    = '0;
        wbs_adr_i    = '0;
        cycles       = 0;
        load_row     = 0;
        patch_total  = 0;
        lcg_state    = 32'hdba88b69;
        build_table();
        cycle_limit = op_tab.size() * 40 + 200;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        check_value("pix_ack_o after reset", 64'(pix_ack_o), 64'd0);
        check_value("query_ack_o after reset", 64'(query_ack_o), 64'd0);
        check_value("wbs_ack_o after reset", 64'(wbs_ack_o), 64'd0);
        check_value("patch_count_o after reset", 64'(patch_count_o), 64'd0);

        for (int i = 0; i < op_tab.size(); i++) apply_entry(i);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- hw/patch_subsys_top.sv
`timescale 1ns/100ps

module patch_subsys_top #(
    parameter int DATA_WIDTH        = patch_pkg::PIX_W,
    parameter int PATCH_SIZE        = patch_pkg::PATCH_SIZE,
    parameter int ADDR_WIDTH        = patch_pkg::ADDR_W_DEF,
    parameter int DEPTH             = patch_pkg::DEPTH_DEF,
    parameter int WB_ADDRESS_OFFSET = patch_pkg::WB_BASE_DEF
) (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             wb_mode_i,
    // Pixel stream
    input  logic                             pix_req_i,
    input  logic [DATA_WIDTH-1:0]            pix_i,
    output logic                             pix_ack_o,
    output logic [ADDR_WIDTH:0]              patch_count_o,
    // Query
    input  logic                             query_req_i,
    input  logic [ADDR_WIDTH-1:0]            query_addr_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0] cand_patch_i,
    output logic                             query_ack_o,
    output logic [patch_pkg::SAD_W-1:0]      sad_o,
    // Wishbone slave
    input  logic                             wbs_stb_i,
    input  logic                             wbs_cyc_i,
    input  logic                             wbs_we_i,
    input  logic [3:0]                       wbs_sel_i,
    input  logic [31:0]                      wbs_dat_i,
    input  logic [31:0]                      wbs_adr_i,
    output logic                             wbs_ack_o,
    output logic [31:0]                      wbs_dat_o
);

    logic                             wr_req;
    logic [ADDR_WIDTH-1:0]            wr_addr;
    logic [DATA_WIDTH*PATCH_SIZE-1:0] wr_patch;
    logic                             wr_ack;
    logic                             rd1_csb_n;
    logic [ADDR_WIDTH-1:0]            rd1_addr;
    logic [DATA_WIDTH*PATCH_SIZE-1:0] rd1_patch;

    patch_loader #(
        .DATA_WIDTH (DATA_WIDTH),
        .PATCH_SIZE (PATCH_SIZE),
        .ADDR_WIDTH (ADDR_WIDTH),
        .DEPTH      (DEPTH)
    ) i_loader (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .pix_req_i     (pix_req_i),
        .pix_i         (pix_i),
        .pix_ack_o     (pix_ack_o),
        .wr_req_o      (wr_req),
        .wr_addr_o     (wr_addr),
        .wr_patch_o    (wr_patch),
        .wr_ack_i      (wr_ack),
        .patch_count_o (patch_count_o)
    );

    query_patch_mem #(
        .DATA_WIDTH        (DATA_WIDTH),
        .PATCH_SIZE        (PATCH_SIZE),
        .ADDR_WIDTH        (ADDR_WIDTH),
        .DEPTH             (DEPTH),
        .WB_ADDRESS_OFFSET (WB_ADDRESS_OFFSET)
    ) i_mem (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wb_mode_i   (wb_mode_i),
        .wr_req_i    (wr_req),
        .wr_addr_i   (wr_addr),
        .wr_patch_i  (wr_patch),
        .wr_ack_o    (wr_ack),
        .rd1_csb_n_i (rd1_csb_n),
        .rd1_addr_i  (rd1_addr),
        .rd1_patch_o (rd1_patch),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o)
    );

    patch_sad #(
        .DATA_WIDTH (DATA_WIDTH),
        .PATCH_SIZE (PATCH_SIZE),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_sad (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .query_req_i  (query_req_i),
        .query_addr_i (query_addr_i),
        .cand_patch_i (cand_patch_i),
        .query_ack_o  (query_ack_o),
        .sad_o        (sad_o),
        .rd1_csb_n_o  (rd1_csb_n),
        .rd1_addr_o   (rd1_addr),
        .rd1_patch_i  (rd1_patch)
    );

endmodule

//--- hw/patch_sad.sv
`timescale 1ns/100ps

module patch_sad #(
    parameter int DATA_WIDTH = patch_pkg::PIX_W,
    parameter int PATCH_SIZE = patch_pkg::PATCH_SIZE,
    parameter int ADDR_WIDTH = patch_pkg::ADDR_W_DEF
) (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             query_req_i,
    input  logic [ADDR_WIDTH-1:0]            query_addr_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0] cand_patch_i,
    output logic                             query_ack_o,
    output logic [patch_pkg::SAD_W-1:0]      sad_o,
    output logic                             rd1_csb_n_o,
    output logic [ADDR_WIDTH-1:0]            rd1_addr_o,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0] rd1_patch_i
);
    import patch_pkg::*;

    sad_state_e            state_q;
    logic                  ack_q;
    logic [DATA_WIDTH-1:0] diff_q [PATCH_SIZE];
    logic [SAD_W-1:0]      sad_q;
    logic [SAD_W-1:0]      sum;

    function automatic logic [DATA_WIDTH-1:0] abs_diff(
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        return (a > b) ? (a - b) : (b - a);
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE:  if (query_req_i) state_q <= FETCH;
                FETCH: state_q <= WAIT;    // Read issued on port 1
                WAIT:  state_q <= CALC;
                CALC:  state_q <= DONE;
                DONE: begin
                    if (!ack_q) begin
                        ack_q <= 1'b1;
                    end else if (!query_req_i) begin
                        ack_q   <= 1'b0;   // Four-phase release
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Per-pixel distance straight off the SRAM output
    always_ff @(posedge clk) begin
        if (state_q == WAIT) begin
            for (int k = 0; k < PATCH_SIZE; k++) begin
                diff_q[k] <= abs_diff(rd1_patch_i[k*DATA_WIDTH +: DATA_WIDTH],
                                      cand_patch_i[k*DATA_WIDTH +: DATA_WIDTH]);
            end
        end
        if (state_q == CALC) begin
            sad_q <= sum;
        end
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < PATCH_SIZE; k++) begin
            sum = sum + SAD_W'(diff_q[k]);
        end
    end

    assign rd1_csb_n_o = (state_q != FETCH);
    assign rd1_addr_o  = query_addr_i;   // Held by the requester
    assign query_ack_o = ack_q;
    assign sad_o       = sad_q;

    // Ack only ever answers a live request
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !query_req_i && !query_ack_o |=> !query_ack_o
    ) else $error("query_ack_o rose without a request");

endmodule

//--- hw/patch_loader.sv
`timescale 1ns/100ps

module patch_loader #(
    parameter int DATA_WIDTH = patch_pkg::PIX_W,
    parameter int PATCH_SIZE = patch_pkg::PATCH_SIZE,
    parameter int ADDR_WIDTH = patch_pkg::ADDR_W_DEF,
    parameter int DEPTH      = patch_pkg::DEPTH_DEF
) (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             pix_req_i,
    input  logic [DATA_WIDTH-1:0]            pix_i,
    output logic                             pix_ack_o,
    output logic                             wr_req_o,
    output logic [ADDR_WIDTH-1:0]            wr_addr_o,
    output logic [DATA_WIDTH*PATCH_SIZE-1:0] wr_patch_o,
    input  logic                             wr_ack_i,
    output logic [ADDR_WIDTH:0]              patch_count_o
);
    import patch_pkg::*;

    localparam int PATCH_W = DATA_WIDTH * PATCH_SIZE;
    localparam int IDX_W   = $clog2(PATCH_SIZE);

    load_state_e           state_q;
    logic [IDX_W-1:0]      idx_q;
    logic [PATCH_W-1:0]    patch_q;
    logic                  pix_ack_q;
    logic                  wr_req_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ADDR_WIDTH:0]   count_q;
    logic                  take_pix;
    logic                  last_pix;

    assign take_pix = (state_q == COLLECT) && pix_req_i && !pix_ack_q;
    assign last_pix = (idx_q == IDX_W'(PATCH_SIZE - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= COLLECT;
            idx_q     <= '0;
            pix_ack_q <= 1'b0;
            wr_req_q  <= 1'b0;
            addr_q    <= '0;
            count_q   <= '0;
        end else begin
            case (state_q)
                COLLECT: begin
                    if (take_pix) begin
                        if (last_pix) begin
                            // Last pixel is acked only once its row is stored
                            idx_q    <= '0;
                            wr_req_q <= 1'b1;
                            state_q  <= WRITE;
                        end else begin
                            idx_q     <= idx_q + 1'b1;
                            pix_ack_q <= 1'b1;
                        end
                    end else if (pix_ack_q && !pix_req_i) begin
                        pix_ack_q <= 1'b0;   // Return to zero phase
                    end
                end
                WRITE: begin
                    if (wr_ack_i) begin
                        wr_req_q  <= 1'b0;
                        pix_ack_q <= 1'b1;
                        addr_q    <= (addr_q == ADDR_WIDTH'(DEPTH - 1)) ? '0 : addr_q + 1'b1;
                        count_q   <= count_q + 1'b1;
                        state_q   <= COLLECT;
                    end
                end
                default: state_q <= COLLECT;
            endcase
        end
    end

    // New pixel enters at the top so the first one ends in the low bits
    always_ff @(posedge clk) begin
        if (take_pix) begin
            patch_q <= {pix_i, patch_q[PATCH_W-1:DATA_WIDTH]};
        end
    end

    assign pix_ack_o     = pix_ack_q;
    assign wr_req_o      = wr_req_q;
    assign wr_addr_o     = addr_q;
    assign wr_patch_o    = patch_q;
    assign patch_count_o = count_q;

    // Row and payload hold still until the memory grants the write
    a_wr_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wr_req_o && !wr_ack_i |=> $stable(wr_patch_o) && $stable(wr_addr_o)
    ) else $error("write payload changed while waiting for wr_ack");

endmodule

//--- query_patch_mem/query_patch_mem.sv
`timescale 1ns/100ps

module query_patch_mem #(
    parameter int DATA_WIDTH        = patch_pkg::PIX_W,
    parameter int PATCH_SIZE        = patch_pkg::PATCH_SIZE,
    parameter int ADDR_WIDTH        = patch_pkg::ADDR_W_DEF,
    parameter int DEPTH             = patch_pkg::DEPTH_DEF,
    parameter int WB_ADDRESS_OFFSET = patch_pkg::WB_BASE_DEF
) (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             wb_mode_i,   // Host owns port 0
    // Loader write side
    input  logic                             wr_req_i,
    input  logic [ADDR_WIDTH-1:0]            wr_addr_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0] wr_patch_i,
    output logic                             wr_ack_o,
    // Matcher read side
    input  logic                             rd1_csb_n_i,
    input  logic [ADDR_WIDTH-1:0]            rd1_addr_i,
    output logic [DATA_WIDTH*PATCH_SIZE-1:0] rd1_patch_o,
    // Wishbone slave
    input  logic                             wbs_stb_i,
    input  logic                             wbs_cyc_i,
    input  logic                             wbs_we_i,
    input  logic [3:0]                       wbs_sel_i,
    input  logic [31:0]                      wbs_dat_i,
    input  logic [31:0]                      wbs_adr_i,
    output logic                             wbs_ack_o,
    output logic [31:0]                      wbs_dat_o
);
    import patch_pkg::*;

    localparam int PATCH_W = DATA_WIDTH * PATCH_SIZE;
    localparam int LANES   = ROW_W / 8;

    logic                  wb_start;
    logic                  wb_busy_q;
    logic                  rd_pend_q;
    logic                  wbs_ack_q;
    logic                  hi_sel_q;
    logic [31:0]           wbs_dat_q;
    logic [31:0]           wb_row;
    logic [2:0]            wb_lane;
    logic                  wr_ack_q;

    logic                  csb0;
    logic                  web0;
    logic [ADDR_WIDTH-1:0] addr0;
    logic [LANES-1:0]      wmask0;
    logic [ROW_W-1:0]      din0;
    logic [ROW_W-1:0]      dout0;
    logic [ROW_W-1:0]      dout1;

    assign wb_row   = wbs_adr_i - 32'(WB_ADDRESS_OFFSET);
    assign wb_lane  = wbs_dat_i[13:11];   // Lane index travels in the data word
    assign wb_start = wb_mode_i && wbs_cyc_i && wbs_stb_i && !wb_busy_q;

    // Host transfer tracking, write acks after one cycle and read after two
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_busy_q <= 1'b0;
            rd_pend_q <= 1'b0;
            wbs_ack_q <= 1'b0;
        end else begin
            wbs_ack_q <= 1'b0;
            if (wb_start) begin
                wb_busy_q <= 1'b1;
                if (wbs_we_i) begin
                    wbs_ack_q <= 1'b1;
                end else begin
                    rd_pend_q <= 1'b1;
                end
            end
            if (rd_pend_q) begin
                rd_pend_q <= 1'b0;
                wbs_ack_q <= 1'b1;   // SRAM data arrives this cycle
            end
            if (wbs_ack_q) begin
                wb_busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start) begin
            hi_sel_q <= wbs_dat_i[11];
        end
        if (rd_pend_q) begin
            wbs_dat_q <= hi_sel_q ? 32'(dout0[PATCH_W-1:32]) : dout0[31:0];
        end
    end

    assign wbs_ack_o = wbs_ack_q;
    assign wbs_dat_o = wbs_dat_q;

    // Loader grant, held off while the host owns the port
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ack_q <= 1'b0;
        end else begin
            wr_ack_q <= wr_req_i && !wb_mode_i && !wr_ack_q;
        end
    end

    assign wr_ack_o = wr_ack_q && !wb_mode_i;   // Write happens in the ack cycle

    // Port 0 source select
    always_comb begin
        if (wb_mode_i) begin
            csb0   = !wb_start;
            web0   = !wbs_we_i;
            addr0  = wb_row[ADDR_WIDTH-1:0];
            wmask0 = LANES'(1) << wb_lane;                   // Single byte lane
            din0   = ROW_W'(wbs_dat_i[7:0]) << {wb_lane, 3'b000};
        end else begin
            csb0   = !wr_ack_o;
            web0   = 1'b0;
            addr0  = wr_addr_i;
            wmask0 = '1;
            din0   = ROW_W'(wr_patch_i);
        end
    end

    sram_1rw1r #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DEPTH      (DEPTH)
    ) i_ram (
        .clk      (clk),
        .csb0_i   (csb0),
        .web0_i   (web0),
        .wmask0_i (wmask0),
        .addr0_i  (addr0),
        .din0_i   (din0),
        .dout0_o  (dout0),
        .csb1_i   (rd1_csb_n_i),
        .addr1_i  (rd1_addr_i),
        .dout1_o  (dout1)
    );

    assign rd1_patch_o = dout1[PATCH_W-1:0];

    // Each host transfer gets exactly one ack cycle
    a_single_ack: assert property (
        @(posedge clk) disable iff (!arst_n_i) wbs_ack_o |=> !wbs_ack_o
    ) else $error("wbs_ack_o held for two cycles");

endmodule

//--- query_patch_mem/sram_1rw1r.sv
`timescale 1ns/100ps

module sram_1rw1r #(
    parameter int ADDR_WIDTH = patch_pkg::ADDR_W_DEF,
    parameter int DEPTH      = patch_pkg::DEPTH_DEF
) (
    input  logic                         clk,
    // Port 0, read or write
    input  logic                         csb0_i,
    input  logic                         web0_i,
    input  logic [patch_pkg::ROW_W/8-1:0] wmask0_i,
    input  logic [ADDR_WIDTH-1:0]        addr0_i,
    input  logic [patch_pkg::ROW_W-1:0]  din0_i,
    output logic [patch_pkg::ROW_W-1:0]  dout0_o,
    // Port 1, read only
    input  logic                         csb1_i,
    input  logic [ADDR_WIDTH-1:0]        addr1_i,
    output logic [patch_pkg::ROW_W-1:0]  dout1_o
);
    import patch_pkg::*;

    localparam int LANES = ROW_W / 8;

    logic [ROW_W-1:0] mem [DEPTH];

    // Port 0 masked write or registered read
    always_ff @(posedge clk) begin
        if (!csb0_i) begin
            if (!web0_i) begin
                for (int b = 0; b < LANES; b++) begin
                    if (wmask0_i[b]) begin
                        mem[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
                    end
                end
            end else begin
                dout0_o <= mem[addr0_i];   // Output keeps last read during a write
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!csb1_i) begin
            dout1_o <= mem[addr1_i];
        end
    end

    // An active port must address an existing row
    a_addr0_range: assert property (@(posedge clk) !csb0_i |-> (addr0_i < DEPTH))
        else $error("port 0 address %0d beyond depth", addr0_i);

    a_addr1_range: assert property (@(posedge clk) !csb1_i |-> (addr1_i < DEPTH))
        else $error("port 1 address %0d beyond depth", addr1_i);

endmodule

//--- common/patch_pkg.sv
package patch_pkg;

    // Pixel and patch geometry
    localparam int PIX_W      = 11;
    localparam int PATCH_SIZE = 5;   // Pixels per patch

    // Physical row of the patch SRAM, eight byte lanes
    localparam int ROW_W = 64;

    // Default memory sizing
    localparam int DEPTH_DEF  = 512;
    localparam int ADDR_W_DEF = 9;

    localparam int WB_BASE_DEF = 557;   // Wishbone row base address

    // Width of the SAD result, 5 * 2047 = 10235 fits
    localparam int SAD_W = 14;

    // Loader FSM
    typedef enum logic {
        COLLECT,   // Gathering pixels of the current patch
        WRITE      // Waiting for the row write to be granted
    } load_state_e;

    // Matcher FSM
    typedef enum logic [2:0] {
        IDLE,
        FETCH,     // Port 1 chip select active
        WAIT,      // Row data on the read port
        CALC,      // Summing the registered differences
        DONE       // Result held until the request drops
    } sad_state_e;

endpackage
